/* turfio_hsk.f */
design/turfio_regs_pkg.sv
design/turfio_uart_pkg.sv
design/uart_retime.sv
design/uart_route.sv
design/turfio_ctrl_regs.sv
design/turfio_hsk_top.sv
verif/turfio_clk_gen.sv
verif/turfio_hsk_tb.sv

/* verif/turfio_hsk_tb.sv */
`timescale 1ns/1ps

module turfio_hsk_tb;

    localparam int BAUD       = 16;
    localparam int SAMPLE     = 12;
    // Open-drain rise lag well under the sample point
    localparam int RISE_DELAY = 4;
    localparam int TIMEOUT    = 200;
    localparam turfio_regs_pkg::apb_data_t EXP_IDENT = "TFIO";

    logic init_clk;
    logic reset;
    turfio_regs_pkg::apb_req_t    apb_req;
    turfio_regs_pkg::apb_rsp_t    apb_rsp;
    turfio_regs_pkg::crate_conf_t crate_conf;
    logic dbg_rx, dbg_tx, turf_rx, tctrl_b, turf_tx, surf_tx, surf_rx;
    logic enable_crate, enable_3v3;
    integer seed = 7139;
    string  test_name;

    turfio_clk_gen u_clk (.init_clk(init_clk), .reset_o(reset));

    turfio_hsk_top #(.SAMPLE_POINT(SAMPLE), .BAUD_PERIOD(BAUD)) UUT (
        .init_clk(init_clk), .reset_i(reset),
        .apb_req_i(apb_req), .apb_rsp_o(apb_rsp),
        .dbg_rx_i(dbg_rx), .dbg_tx_o(dbg_tx),
        .turf_rx_i(turf_rx), .tctrl_b_i(tctrl_b), .turf_tx_o(turf_tx),
        .surf_tx_i(surf_tx), .surf_rx_o(surf_rx),
        .crate_conf_i(crate_conf),
        .enable_crate_o(enable_crate), .enable_3v3_o(enable_3v3)
    );

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_data(input string what, input turfio_regs_pkg::apb_data_t exp,
                              input turfio_regs_pkg::apb_data_t act);
        if (act !== exp) stop_on_error($sformatf("Fail %s %s: expected %h, actual %h",
                                                 test_name, what, exp, act));
    endtask

    task automatic check_level(input string what, input logic exp, input logic act);
        if (act !== exp) stop_on_error($sformatf("Fail %s %s: expected %b, actual %b",
                                                 test_name, what, exp, act));
    endtask

    task automatic check_count(input string what, input turfio_uart_pkg::rx_count_t exp,
                               input turfio_uart_pkg::rx_count_t act);
        if (act !== exp) stop_on_error($sformatf("Fail %s %s: expected %0d, actual %0d",
                                                 test_name, what, exp, act));
    endtask

    task automatic check_err(input string what, input logic exp, input logic act);
        if (act !== exp) stop_on_error($sformatf("Fail %s %s pslverr: expected %b, actual %b",
                                                 test_name, what, exp, act));
    endtask

    //////////////////////////////
    // Drivers
    //////////////////////////////
    // Setup and access phases held until pready
    task automatic apb_transfer(input logic wr, input turfio_regs_pkg::apb_addr_t addr,
                                input turfio_regs_pkg::apb_data_t wdata,
                                output turfio_regs_pkg::apb_data_t rdata, output logic err);
        int waited;
        @(posedge init_clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge init_clk);
        apb_req.penable <= 1'b1;
        waited = 0;
        @(negedge init_clk);
        while (!apb_rsp.pready) begin
            if (waited == TIMEOUT) stop_on_error("APB transfer never saw pready");
            waited++;
            @(negedge init_clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        // Write lands on this edge
        @(posedge init_clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input turfio_regs_pkg::apb_addr_t addr,
                             input turfio_regs_pkg::apb_data_t wdata, output logic err);
        turfio_regs_pkg::apb_data_t unused;
        apb_transfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input turfio_regs_pkg::apb_addr_t addr,
                            output turfio_regs_pkg::apb_data_t rdata, output logic err);
        apb_transfer(1'b0, addr, '0, rdata, err);
    endtask

    // Two sync stages plus output register
    task automatic wait_route_latency();
        repeat (3) @(posedge init_clk);
        @(negedge init_clk);
    endtask

    // Start bit and 8 data bits LSB first and stop bit
    // Rising edges lag the bit boundary
    task automatic send_frame(input logic [7:0] data);
        logic [9:0] bits;
        logic       prev;
        bits = {1'b1, data, 1'b0};
        prev = 1'b1;
        for (int i = 0; i < 10; i++) begin
            for (int c = 0; c < BAUD; c++) begin
                @(posedge init_clk);
                surf_tx <= (bits[i] && !prev && c < RISE_DELAY) ? 1'b0 : bits[i];
            end
            prev = bits[i];
        end
    endtask

    function automatic logic crate_out(input logic use_dbg);
        return use_dbg ? dbg_tx : turf_tx;
    endfunction

    // Decode at bit centres from the first low level
    task automatic receive_frame(input logic use_dbg, output logic [7:0] data);
        int waited;
        waited = 0;
        @(negedge init_clk);
        while (crate_out(use_dbg)) begin
            if (waited == TIMEOUT) stop_on_error("No start bit reached the crate output");
            waited++;
            @(negedge init_clk);
        end
        repeat (BAUD / 2) @(negedge init_clk);
        check_level("start bit", 1'b0, crate_out(use_dbg));
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD) @(negedge init_clk);
            data[i] = crate_out(use_dbg);
        end
        repeat (BAUD) @(negedge init_clk);
        check_level("stop bit", 1'b1, crate_out(use_dbg));
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////
    task automatic test_reset_state();
        turfio_regs_pkg::apb_data_t rdata;
        logic err;
        test_name = "reset_state";
        apb_read(turfio_regs_pkg::REG_IDENT, rdata, err);
        check_err("ident read", 1'b0, err);
        check_data("ident", EXP_IDENT, rdata);
        apb_read(turfio_regs_pkg::REG_VERSION, rdata, err);
        check_data("version", turfio_regs_pkg::VERSION_VALUE, rdata);
        apb_read(turfio_regs_pkg::REG_CTRL, rdata, err);
        check_data("ctrl", '0, rdata);
        @(negedge init_clk);
        check_level("enable_crate_o", 1'b0, enable_crate);
        check_level("enable_3v3_o", 1'b0, enable_3v3);
        check_level("dbg_tx_o", 1'b1, dbg_tx);
        check_level("turf_tx_o", 1'b1, turf_tx);
        check_level("surf_rx_o", 1'b1, surf_rx);
    endtask

    task automatic test_register_access();
        turfio_regs_pkg::apb_data_t rdata;
        logic       err;
        logic [3:0] val;
        test_name = "register_access";
        for (int i = 0; i < 8; i++) begin
            val = 4'($random(seed));
            apb_write(turfio_regs_pkg::REG_CTRL, {28'd0, val}, err);
            check_err("ctrl write", 1'b0, err);
            apb_read(turfio_regs_pkg::REG_CTRL, rdata, err);
            check_data("ctrl readback", {28'd0, val}, rdata);
            @(negedge init_clk);
            check_level("enable_crate_o", val[2], enable_crate);
            check_level("enable_3v3_o", val[3], enable_3v3);
        end
        // Ident write is dropped silently
        apb_write(turfio_regs_pkg::REG_IDENT, 32'hFFFF_FFFF, err);
        check_err("ident write", 1'b0, err);
        apb_read(turfio_regs_pkg::REG_IDENT, rdata, err);
        check_data("ident after write", EXP_IDENT, rdata);
        apb_read(12'h010, rdata, err);
        check_err("unmapped read", 1'b1, err);
        check_data("unmapped data", '0, rdata);
        // Straps in [9:8] and no frames yet
        @(posedge init_clk);
        crate_conf <= 2'b01;
        apb_read(turfio_regs_pkg::REG_STAT, rdata, err);
        check_data("stat", {22'd0, 2'b01, 8'd0}, rdata);
        apb_write(turfio_regs_pkg::REG_CTRL, '0, err);
    endtask

    task automatic test_local_path();
        logic err;
        logic lvl;
        test_name = "local_path";
        apb_write(turfio_regs_pkg::REG_CTRL, 32'h3, err);
        check_err("ctrl write", 1'b0, err);
        for (int i = 0; i < 8; i++) begin
            lvl = (i < 4) ? ~i[0] : 1'($random(seed));
            @(posedge init_clk);
            dbg_rx <= lvl;
            wait_route_latency();
            check_level("surf_rx_o", lvl, surf_rx);
            check_level("turf_tx_o", 1'b1, turf_tx);
        end
        @(posedge init_clk);
        dbg_rx <= 1'b1;
    endtask

    task automatic test_turf_path();
        logic err;
        logic lvl;
        test_name = "turf_path";
        apb_write(turfio_regs_pkg::REG_CTRL, 32'h2, err);
        check_err("ctrl write", 1'b0, err);
        for (int i = 0; i < 8; i++) begin
            lvl = (i < 4) ? i[0] : 1'($random(seed));
            @(posedge init_clk);
            tctrl_b <= 1'b0;
            turf_rx <= lvl;
            wait_route_latency();
            check_level("surf_rx_o", lvl, surf_rx);
            check_level("dbg_tx_o", 1'b1, dbg_tx);
        end
        // TURF detached and then bridge off
        @(posedge init_clk);
        turf_rx <= 1'b0;
        tctrl_b <= 1'b1;
        wait_route_latency();
        check_level("surf_rx_o tctrl high", 1'b1, surf_rx);
        @(posedge init_clk);
        tctrl_b <= 1'b0;
        apb_write(turfio_regs_pkg::REG_CTRL, '0, err);
        wait_route_latency();
        check_level("surf_rx_o bridge off", 1'b1, surf_rx);
        @(posedge init_clk);
        turf_rx <= 1'b1;
        tctrl_b <= 1'b1;
    endtask

    task automatic test_retimed_frames();
        turfio_regs_pkg::apb_data_t rdata;
        turfio_uart_pkg::rx_count_t count_exp;
        logic [7:0] sent;
        logic [7:0] got;
        logic       err;
        test_name = "retimed_frames";
        count_exp = '0;
        // TURF side first and then the debug port
        for (int mode = 0; mode < 2; mode++) begin
            apb_write(turfio_regs_pkg::REG_CTRL, (mode == 1) ? 32'h3 : 32'h2, err);
            check_err("ctrl write", 1'b0, err);
            for (int k = 0; k < 3; k++) begin
                sent = 8'($random(seed));
                fork
                    send_frame(sent);
                    receive_frame(mode == 1, got);
                join
                check_data("decoded byte", {24'd0, sent}, {24'd0, got});
                count_exp++;
                apb_read(turfio_regs_pkg::REG_STAT, rdata, err);
                check_count("frame count", count_exp, rdata[7:0]);
            end
        end
        // Line stays idle with the bridge off
        apb_write(turfio_regs_pkg::REG_CTRL, '0, err);
        fork
            send_frame(8'($random(seed)));
            repeat (10 * BAUD + SAMPLE) begin
                @(negedge init_clk);
                check_level("turf_tx_o bridge off", 1'b1, turf_tx);
            end
        join
        apb_read(turfio_regs_pkg::REG_STAT, rdata, err);
        check_count("frame count bridge off", count_exp, rdata[7:0]);
    endtask

    initial begin
        int waited;
        apb_req    = '0;
        dbg_rx     = 1'b1;
        turf_rx    = 1'b1;
        tctrl_b    = 1'b1;
        surf_tx    = 1'b1;
        crate_conf = 2'b10;
        waited     = 0;
        @(negedge init_clk);
        while (reset) begin
            if (waited == TIMEOUT) stop_on_error("Reset was never released");
            waited++;
            @(negedge init_clk);
        end
        test_reset_state();
        test_register_access();
        test_local_path();
        test_turf_path();
        test_retimed_frames();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verif/turfio_clk_gen.sv */
`timescale 1ns/1ps

module turfio_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic init_clk,
    output logic reset_o
);

    // Free running clock
    initial begin
        init_clk = 1'b0;
        forever #(PERIOD_NS / 2) init_clk = ~init_clk;
    end

    // Reset released on a rising edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge init_clk);
        reset_o <= 1'b0;
    end

endmodule

/* design/turfio_hsk_top.sv */
`timescale 1ns/1ps

module turfio_hsk_top #(
    parameter int SAMPLE_POINT = 120,
    parameter int BAUD_PERIOD  = 160
) (
    input  logic                          init_clk,
    input  logic                          reset_i,
    input  turfio_regs_pkg::apb_req_t    apb_req_i,
    output turfio_regs_pkg::apb_rsp_t    apb_rsp_o,
    input  logic                          dbg_rx_i,
    output logic                          dbg_tx_o,
    input  logic                          turf_rx_i,
    input  logic                          tctrl_b_i,
    output logic                          turf_tx_o,
    input  logic                          surf_tx_i,
    output logic                          surf_rx_o,
    input  turfio_regs_pkg::crate_conf_t crate_conf_i,
    output logic                          enable_crate_o,
    output logic                          enable_3v3_o
);

    turfio_regs_pkg::ctrl_reg_t   ctrl;
    turfio_uart_pkg::route_ctrl_t route;
    // Retimed crate transmit line
    logic                         crate_rx;
    logic                         rx_frame_done;

    // Routing bits out of CTRL
    assign route.hsk_local       = ctrl.hsk_local;
    assign route.crate_bridge_en = ctrl.crate_bridge_en;

    turfio_ctrl_regs u_regs (
        .init_clk        (init_clk),
        .reset_i         (reset_i),
        .apb_req_i       (apb_req_i),
        .apb_rsp_o       (apb_rsp_o),
        .crate_conf_i    (crate_conf_i),
        .rx_frame_done_i (rx_frame_done),
        .ctrl_o          (ctrl),
        .enable_crate_o  (enable_crate_o),
        .enable_3v3_o    (enable_3v3_o)
    );

    uart_route u_route (
        .init_clk   (init_clk),
        .reset_i    (reset_i),
        .route_i    (route),
        .dbg_rx_i   (dbg_rx_i),
        .turf_rx_i  (turf_rx_i),
        .tctrl_b_i  (tctrl_b_i),
        .crate_rx_i (crate_rx),
        .dbg_tx_o   (dbg_tx_o),
        .turf_tx_o  (turf_tx_o),
        .surf_rx_o  (surf_rx_o)
    );

    // Default timing suits 0.5 Mbaud with a 1 us rise
    uart_retime #(
        .SAMPLE_POINT (SAMPLE_POINT),
        .BAUD_PERIOD  (BAUD_PERIOD)
    ) u_retime (
        .init_clk        (init_clk),
        .reset_i         (reset_i),
        .crate_en_i      (ctrl.crate_bridge_en),
        .surf_tx_i       (surf_tx_i),
        .rx_retimed_o    (crate_rx),
        .rx_frame_done_o (rx_frame_done)
    );

endmodule

/* design/turfio_ctrl_regs.sv */
`timescale 1ns/1ps

module turfio_ctrl_regs (
    input  logic                           init_clk,
    input  logic                           reset_i,
    input  turfio_regs_pkg::apb_req_t     apb_req_i,
    output turfio_regs_pkg::apb_rsp_t     apb_rsp_o,
    input  turfio_regs_pkg::crate_conf_t  crate_conf_i,
    input  logic                           rx_frame_done_i,
    output turfio_regs_pkg::ctrl_reg_t    ctrl_o,
    output logic                           enable_crate_o,
    output logic                           enable_3v3_o
);

    // First access cycle, wait state not yet served
    logic access_first;
    // Last access cycle, response valid
    logic pready_q;
    logic pslverr_q;
    turfio_regs_pkg::apb_data_t prdata_q;

    // Read mux result
    turfio_regs_pkg::apb_data_t rd_data;
    logic                       addr_hit;

    turfio_regs_pkg::ctrl_reg_t ctrl_q;
    turfio_uart_pkg::rx_count_t rx_count_q;

    assign access_first = apb_req_i.psel & apb_req_i.penable & ~pready_q;

    //////////////////////////////
    // Address decode
    //////////////////////////////
    always_comb begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (apb_req_i.paddr)
            turfio_regs_pkg::REG_IDENT:   rd_data = turfio_regs_pkg::IDENT_VALUE;
            turfio_regs_pkg::REG_VERSION: rd_data = turfio_regs_pkg::VERSION_VALUE;
            turfio_regs_pkg::REG_CTRL:    rd_data = {28'd0, ctrl_q};
            // Count low, straps above
            turfio_regs_pkg::REG_STAT:    rd_data = {22'd0, crate_conf_i, rx_count_q};
            default:                      addr_hit = 1'b0;
        endcase
    end

    // One wait state, response lands in the second access cycle
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else begin
            pready_q  <= access_first;
            pslverr_q <= access_first & ~addr_hit;
        end
    end

    // Unmapped reads come back as zero from the mux
    always_ff @(posedge init_clk) begin
        if (access_first) prdata_q <= rd_data;
    end

    assign apb_rsp_o.prdata  = prdata_q;
    assign apb_rsp_o.pready  = pready_q;
    assign apb_rsp_o.pslverr = pslverr_q;

    //////////////////////////////
    // CTRL and frame count
    //////////////////////////////
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            ctrl_q <= '0;
        end else if (pready_q && apb_req_i.pwrite &&
                     apb_req_i.paddr == turfio_regs_pkg::REG_CTRL) begin
            // Only CTRL is writable, other writes drop silently
            ctrl_q <= turfio_regs_pkg::ctrl_reg_t'(apb_req_i.pwdata[3:0]);
        end
    end

    // Wraps at 256
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            rx_count_q <= '0;
        end else if (rx_frame_done_i) begin
            rx_count_q <= rx_count_q + 1'b1;
        end
    end

    assign ctrl_o         = ctrl_q;
    assign enable_crate_o = ctrl_q.enable_crate;
    assign enable_3v3_o   = ctrl_q.enable_3v3;

    // Master must still be holding the access phase
    a_pready_access: assert property (@(posedge init_clk) disable iff (reset_i)
        apb_rsp_o.pready |-> apb_req_i.psel && apb_req_i.penable);

    // Error only with a completed transfer
    a_err_ready: assert property (@(posedge init_clk) disable iff (reset_i)
        apb_rsp_o.pslverr |-> apb_rsp_o.pready);

endmodule

/* design/uart_route.sv */
`timescale 1ns/1ps

module uart_route (
    input  logic                        init_clk,
    input  logic                        reset_i,
    input  turfio_uart_pkg::route_ctrl_t route_i,
    input  logic                        dbg_rx_i,
    input  logic                        turf_rx_i,
    input  logic                        tctrl_b_i,
    input  logic                        crate_rx_i,
    output logic                        dbg_tx_o,
    output logic                        turf_tx_o,
    output logic                        surf_rx_o
);

    // Bit order {crate, tctrl, turf, dbg}
    // Crate line shares the pipe so every path has equal latency
    logic [3:0] sync_meta;
    logic [3:0] sync_q;

    logic crate_data;
    logic surf_rx_n;
    logic turf_tx_n;
    logic dbg_tx_n;

    // Everything idles high, tctrl high means TURF detached
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            sync_meta <= 4'hF;
            sync_q    <= 4'hF;
        end else begin
            sync_meta <= {crate_rx_i, tctrl_b_i, turf_rx_i, dbg_rx_i};
            sync_q    <= sync_meta;
        end
    end

    //////////////////////////////
    // Routing
    //////////////////////////////
    always_comb begin
        // Bridge off means crate looks idle
        crate_data = route_i.crate_bridge_en ? sync_q[3] : 1'b1;
        if (route_i.hsk_local) begin
            surf_rx_n = sync_q[0];
            dbg_tx_n  = crate_data;
            turf_tx_n = 1'b1;
        end else begin
            // TURF serial only valid with tctrl low
            surf_rx_n = sync_q[2] ? 1'b1 : sync_q[1];
            turf_tx_n = crate_data;
            dbg_tx_n  = 1'b1;
        end
        if (!route_i.crate_bridge_en) surf_rx_n = 1'b1;
    end

    // Registered outputs, glitch free on route changes
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            dbg_tx_o  <= 1'b1;
            turf_tx_o <= 1'b1;
            surf_rx_o <= 1'b1;
        end else begin
            dbg_tx_o  <= dbg_tx_n;
            turf_tx_o <= turf_tx_n;
            surf_rx_o <= surf_rx_n;
        end
    end

    // TURF detached while crate is local
    a_turf_idle: assert property (@(posedge init_clk) disable iff (reset_i)
        route_i.hsk_local |=> turf_tx_o);

endmodule

/* design/uart_retime.sv */
`timescale 1ns/1ps

module uart_retime #(
    parameter int SAMPLE_POINT = 120,
    parameter int BAUD_PERIOD  = 160
) (
    input  logic init_clk,
    input  logic reset_i,
    input  logic crate_en_i,
    input  logic surf_tx_i,
    output logic rx_retimed_o,
    output logic rx_frame_done_o
);

    // Counter compare points
    localparam turfio_uart_pkg::baud_cnt_t SAMPLE_CNT =
        turfio_uart_pkg::baud_cnt_t'(SAMPLE_POINT - 1);
    localparam turfio_uart_pkg::baud_cnt_t BAUD_LAST =
        turfio_uart_pkg::baud_cnt_t'(BAUD_PERIOD - 1);
    localparam turfio_uart_pkg::bit_idx_t LAST_DATA_BIT = 4'd7;

    // Open-drain line, slow rise
    logic rx_meta;
    logic rx_sync;
    // Previous synced level for edge detect
    logic rx_last;
    logic rx_fall;

    turfio_uart_pkg::retime_state_e state_q;
    turfio_uart_pkg::baud_cnt_t     baud_cnt_q;
    turfio_uart_pkg::bit_idx_t      bit_idx_q;
    logic sample_now;
    logic bit_end;

    // Two-flop synchronizer, idles high
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= surf_tx_i;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    assign rx_fall    = rx_last & ~rx_sync;
    assign sample_now = (baud_cnt_q == SAMPLE_CNT);
    assign bit_end    = (baud_cnt_q == BAUD_LAST);

    //////////////////////////////
    // Frame FSM
    //////////////////////////////
    always_ff @(posedge init_clk) begin
        if (reset_i || !crate_en_i) begin
            state_q         <= turfio_uart_pkg::IDLE;
            baud_cnt_q      <= '0;
            bit_idx_q       <= '0;
            rx_retimed_o    <= 1'b1;
            rx_frame_done_o <= 1'b0;
        end else begin
            rx_frame_done_o <= 1'b0;
            baud_cnt_q      <= bit_end ? '0 : baud_cnt_q + 1'b1;
            case (state_q)
                turfio_uart_pkg::IDLE: begin
                    // Bit boundary is the cycle after the edge
                    baud_cnt_q <= '0;
                    bit_idx_q  <= '0;
                    if (rx_fall) state_q <= turfio_uart_pkg::START;
                end
                turfio_uart_pkg::START: begin
                    if (sample_now && rx_sync) begin
                        // Glitch, not a real start bit
                        state_q <= turfio_uart_pkg::IDLE;
                    end else if (sample_now) begin
                        rx_retimed_o <= 1'b0;
                    end else if (bit_end) begin
                        state_q <= turfio_uart_pkg::DATA;
                    end
                end
                turfio_uart_pkg::DATA: begin
                    if (sample_now) rx_retimed_o <= rx_sync;
                    if (bit_end) begin
                        if (bit_idx_q == LAST_DATA_BIT) state_q <= turfio_uart_pkg::STOP;
                        else bit_idx_q <= bit_idx_q + 1'b1;
                    end
                end
                default: begin
                    // Stop bit, frame ends at its sample point
                    if (sample_now) begin
                        rx_retimed_o    <= 1'b1;
                        rx_frame_done_o <= 1'b1;
                        state_q         <= turfio_uart_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    // Line idles high between frames
    a_idle_high: assert property (@(posedge init_clk) disable iff (reset_i)
        state_q == turfio_uart_pkg::IDLE |-> rx_retimed_o);

    // One pulse per frame
    a_done_pulse: assert property (@(posedge init_clk) disable iff (reset_i)
        rx_frame_done_o |=> !rx_frame_done_o);

endmodule

/* design/turfio_uart_pkg.sv */
package turfio_uart_pkg;

    // Cycles within one bit period
    typedef logic [7:0] baud_cnt_t;

    // Data bit position within a frame
    typedef logic [3:0] bit_idx_t;

    // Received frame count, wraps at 256
    typedef logic [7:0] rx_count_t;

    // Retimer frame states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        START = 2'd1,
        DATA  = 2'd2,
        STOP  = 2'd3
    } retime_state_e;

    // Routing control, cut from CTRL bits [1:0]
    typedef struct packed {
        // Crate bus connected at all
        logic crate_bridge_en;
        // Crate goes to the debug port instead of the TURF
        logic hsk_local;
    } route_ctrl_t;

endpackage

/* design/turfio_regs_pkg.sv */
package turfio_regs_pkg;

    // APB byte address and data word
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Master to slave, 47 bits
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // Slave to master, 34 bits
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // CTRL register, hsk_local sits in bit 0
    typedef struct packed {
        logic enable_3v3;
        logic enable_crate;
        logic crate_bridge_en;
        logic hsk_local;
    } ctrl_reg_t;

    // Crate configuration straps
    typedef logic [1:0] crate_conf_t;

    // Word addresses
    localparam apb_addr_t REG_IDENT   = 12'h000;
    localparam apb_addr_t REG_VERSION = 12'h004;
    localparam apb_addr_t REG_CTRL    = 12'h008;
    localparam apb_addr_t REG_STAT    = 12'h00C;

    // ASCII "TFIO"
    localparam apb_data_t IDENT_VALUE   = 32'h5446_494F;
    // Date 0, major 0, minor 2, revision 11
    localparam apb_data_t VERSION_VALUE = {16'h0000, 4'd0, 4'd2, 8'd11};

endpackage
